// ==== bench/csr_testdata.txt ====
# op addr data epc tval pins(ext sw tmr) gap : rdata illegal trap irq cause target priv
# Hex fields, pins in binary, gap in decimal; op f drives no command
1 301 0                0    0        000 0  8000000000101101 0 0 0 0                0    3
1 f14 0                0    0        000 0  5                0 0 0 0                0    3
1 300 0                0    0        000 0  0                0 0 0 0                0    3
0 340 123456789abcdef  0    0        000 0  0                0 0 0 0                0    3
1 340 f000000000000000 0    0        000 0  123456789abcdef  0 0 0 0                0    3
2 340 ff               0    0        000 0  f123456789abcdef 0 0 0 0                0    3
3 340 f5               0    0        000 0  f123456789abcd00 0 0 0 0                0    3
4 340 a                0    0        000 0  15               0 0 0 0                0    3
5 340 3                0    0        000 0  1f               0 0 0 0                0    3
1 340 0                0    0        000 0  1c               0 0 0 0                0    3
1 b00 0                0    0        000 3  15               0 0 0 0                0    3
1 b00 0                0    0        000 0  1a               0 0 0 0                0    3
4 320 1                0    0        000 0  0                0 0 0 0                0    3
1 b00 0                0    0        000 3  1d               0 0 0 0                0    3
1 b00 0                0    0        000 0  1d               0 0 0 0                0    3
0 305 100              0    0        000 0  0                0 0 0 0                0    3
0 341 2000             0    0        000 0  0                0 0 0 0                0    3
0 300 80               0    0        000 0  0                0 0 0 0                0    3
8 000 0                0    0        000 0  0                0 0 0 0                2000 0
1 300 0                3000 30002573 000 0  88               1 1 0 2                100  3
8 000 0                0    0        000 0  0                0 0 0 0                3000 0
6 000 0                4000 dead     000 0  0                0 1 0 8                100  3
1 300 0                0    0        000 0  80               0 0 0 0                0    3
1 342 0                0    0        000 0  8                0 0 0 0                0    3
1 304 80               0    0        000 0  0                0 0 0 0                0    3
8 000 0                0    0        000 0  0                0 0 0 0                4000 0
f 000 0                5000 0        001 0  0                0 1 1 8000000000000007 100  3
1 300 0                0    0        000 0  80               0 0 0 0                0    3
1 341 0                0    0        000 0  5000             0 0 0 0                0    3
a 000 0                6000 1001     000 0  0                0 1 0 4                100  3
1 343 0                0    0        000 0  1001             0 0 0 0                0    3
7 000 0                7000 0        000 0  0                0 1 0 3                100  3
1 300 0                0    0        000 0  1800             0 0 0 0                0    3

// ==== bench/csr_checks.svh ====
`ifndef CSR_CHECKS_SVH
`define CSR_CHECKS_SVH

// Error counters, summed up in the closing report
int check_cnt     = 0;
int mismatch_cnt  = 0;
int other_err_cnt = 0;

task automatic word_check
  (input string            name
   , input logic [`XLEN-1:0] got
   , input logic [`XLEN-1:0] exp
   );
   check_cnt++;
   if (got !== exp)
   begin
      mismatch_cnt++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
   end
endtask

task automatic mode_check
  (input string                  name
   , input csr_isa_pkg::priv_e   got
   , input csr_isa_pkg::priv_e   exp
   );
   check_cnt++;
   if (got !== exp)
   begin
      mismatch_cnt++;
      $display("Fail at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
   end
endtask

task automatic flag_check
  (input string  name
   , input logic got
   , input logic exp
   );
   check_cnt++;
   if (got !== exp)
   begin
      mismatch_cnt++;
      $display("Fail at %0t ns: %s is %b, expected %b", $time, name, got, exp);
   end
endtask

`endif

// ==== bench/tb_csr_unit.sv ====
`timescale 1ns/1ns
`include "csr_macros.svh"

module tb_csr_unit;

   import csr_isa_pkg::*;
   import csr_cmd_pkg::*;

   localparam int               RESP_TIMEOUT = 20;
   localparam logic [`XLEN-1:0] HART_ID      = `XLEN'h5;

   logic             clk_i = 1'b0;
   logic             rst_i;
   logic             cmd_v_i;
   csr_op_e          cmd_op_i;
   logic [11:0]      cmd_addr_i;
   logic [`XLEN-1:0] cmd_data_i, epc_i, tval_i, hartid_i;
   logic             timer_irq_i, software_irq_i, external_irq_i, instret_i;
   logic             resp_v_o, illegal_o, trap_o, irq_o;
   logic [`XLEN-1:0] rdata_o, cause_o, target_pc_o;
   priv_e            priv_o;

   `include "csr_checks.svh"

   // 40 ns period
   always #20 clk_i = ~clk_i;

   csr_unit dut0
     (.clk_i           (clk_i)
      , .rst_i         (rst_i)
      , .cmd_v_i       (cmd_v_i)
      , .cmd_op_i      (cmd_op_i)
      , .cmd_addr_i    (cmd_addr_i)
      , .cmd_data_i    (cmd_data_i)
      , .epc_i         (epc_i)
      , .tval_i        (tval_i)
      , .timer_irq_i   (timer_irq_i)
      , .software_irq_i(software_irq_i)
      , .external_irq_i(external_irq_i)
      , .instret_i     (instret_i)
      , .hartid_i      (hartid_i)
      , .resp_v_o      (resp_v_o)
      , .rdata_o       (rdata_o)
      , .illegal_o     (illegal_o)
      , .trap_o        (trap_o)
      , .irq_o         (irq_o)
      , .cause_o       (cause_o)
      , .target_pc_o   (target_pc_o)
      , .priv_o        (priv_o)
      );

   // Outputs are sampled on the falling edge
   task automatic wait_for_response(output logic seen);
      int cycles;
      cycles = 0;
      @(negedge clk_i);
      while (!resp_v_o && cycles < RESP_TIMEOUT)
      begin
         @(negedge clk_i);
         cycles++;
      end
      seen = resp_v_o;
   endtask

   initial
   begin
      int               fd, fields, rec_cnt, rec_gap;
      string            line;
      logic [3:0]       rec_op;
      logic [11:0]      rec_addr;
      logic [`XLEN-1:0] rec_data, rec_epc, rec_tval;
      logic [2:0]       rec_pins;
      logic [`XLEN-1:0] exp_rdata, exp_cause, exp_target;
      logic             exp_illegal, exp_trap, exp_irq, seen, timed_out;
      logic [1:0]       exp_priv;
      rst_i          = 1'b1;
      cmd_v_i        = 1'b0;
      cmd_op_i       = e_none;
      cmd_addr_i     = '0;
      cmd_data_i     = '0;
      epc_i          = '0;
      tval_i         = '0;
      timer_irq_i    = 1'b0;
      software_irq_i = 1'b0;
      external_irq_i = 1'b0;
      instret_i      = 1'b0;
      hartid_i       = HART_ID;
      rec_cnt        = 0;
      timed_out      = 1'b0;
      fd = $fopen("bench/csr_testdata.txt", "r");
      if (fd == 0)
      begin
         $display("Could not open the test data file bench/csr_testdata.txt");
         other_err_cnt++;
      end
      repeat (4) @(posedge clk_i);
      rst_i <= 1'b0;
      while (fd != 0 && !timed_out && !$feof(fd))
      begin
         line   = "";
         fields = $fgets(line, fd);
         if (line.len() < 2 || line.substr(0, 0) == "#")
            continue;
         fields = $sscanf(line, "%h %h %h %h %h %b %d %h %b %b %b %h %h %h",
                          rec_op, rec_addr, rec_data, rec_epc, rec_tval, rec_pins, rec_gap,
                          exp_rdata, exp_illegal, exp_trap, exp_irq, exp_cause, exp_target,
                          exp_priv);
         if (fields != 14)
         begin
            $display("Malformed test data record: %s", line);
            other_err_cnt++;
            continue;
         end
         rec_cnt++;
         // Op f drives only the interrupt pins
         @(posedge clk_i);
         cmd_v_i        <= (rec_op != 4'hf);
         cmd_op_i       <= csr_op_e'(rec_op);
         cmd_addr_i     <= rec_addr;
         cmd_data_i     <= rec_data;
         epc_i          <= rec_epc;
         tval_i         <= rec_tval;
         external_irq_i <= rec_pins[2];
         software_irq_i <= rec_pins[1];
         timer_irq_i    <= rec_pins[0];
         @(posedge clk_i);
         cmd_v_i  <= 1'b0;
         cmd_op_i <= e_none;
         wait_for_response(seen);
         if (!seen)
         begin
            $display("No response within %0d cycles for record %0d", RESP_TIMEOUT, rec_cnt);
            other_err_cnt++;
            timed_out = 1'b1;
         end
         else
         begin
            word_check("rdata_o", rdata_o, exp_rdata);
            flag_check("illegal_o", illegal_o, exp_illegal);
            flag_check("trap_o", trap_o, exp_trap);
            flag_check("irq_o", irq_o, exp_irq);
            word_check("cause_o", cause_o, exp_cause);
            word_check("target_pc_o", target_pc_o, exp_target);
            mode_check("priv_o", priv_o, priv_e'(exp_priv));
            repeat (rec_gap) @(posedge clk_i);
         end
      end
      if (fd != 0)
         $fclose(fd);
      $display("Records: %0d, checks: %0d, mismatches: %0d, other errors: %0d",
               rec_cnt, check_cnt, mismatch_cnt, other_err_cnt);
      if (mismatch_cnt == 0 && other_err_cnt == 0 && rec_cnt > 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

// ==== design/csr_cmd_pkg.sv ====
package csr_cmd_pkg;

   typedef enum logic [3:0]
   {
      e_csrrw                = 4'd0,
      e_csrrs                = 4'd1,
      e_csrrc                = 4'd2,
      e_csrrwi               = 4'd3,
      e_csrrsi               = 4'd4,
      e_csrrci               = 4'd5,
      e_ecall                = 4'd6,
      e_ebreak               = 4'd7,
      e_mret                 = 4'd8,
      // Exceptions found by the pipeline
      e_exc_illegal          = 4'd9,
      e_exc_load_misaligned  = 4'd10,
      e_exc_store_misaligned = 4'd11,
      e_none                 = 4'd15
   } csr_op_e;

endpackage

// ==== design/csr_counters.sv ====
`timescale 1ns/1ns
`include "csr_macros.svh"

module csr_counters
  (input                      clk_i
   , input                    rst_i
   , input                    instret_i
   , input [2:0]              cnt_we_i
   , input [`XLEN-1:0]        cnt_wdata_i
   , output logic [`XLEN-1:0] mcycle_o
   , output logic [`XLEN-1:0] minstret_o
   , output logic [`XLEN-1:0] mcountinhibit_o
   );

   logic [`XLEN-1:0] mcycle_r;
   logic [`XLEN-1:0] minstret_r;
   logic [`XLEN-1:0] mcountinhibit_r;

   // Bit 0 stops mcycle, bit 2 stops minstret
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         mcycle_r        <= '0;
         minstret_r      <= '0;
         mcountinhibit_r <= '0;
      end
      else
      begin
         if (cnt_we_i[0])
            mcycle_r <= cnt_wdata_i;
         else if (!mcountinhibit_r[0])
            mcycle_r <= mcycle_r + `XLEN'(1);

         if (cnt_we_i[1])
            minstret_r <= cnt_wdata_i;
         else if (!mcountinhibit_r[2])
            minstret_r <= minstret_r + `XLEN'(instret_i);

         if (cnt_we_i[2])
            mcountinhibit_r <= cnt_wdata_i & `MCOUNTINHIBIT_MASK;
      end
   end

   assign mcycle_o        = mcycle_r;
   assign minstret_o      = minstret_r;
   assign mcountinhibit_o = mcountinhibit_r;

   we_onehot_a : assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(cnt_we_i));

endmodule

// ==== design/csr_file.sv ====
`timescale 1ns/1ns
`include "csr_macros.svh"

module csr_file
  (input                                clk_i
   , input                              rst_i
   , input                              cmd_v_i
   , input csr_cmd_pkg::csr_op_e        cmd_op_i
   , input [11:0]                       cmd_addr_i
   , input [`XLEN-1:0]                  cmd_data_i
   , input [`XLEN-1:0]                  hartid_i
   , input csr_isa_pkg::priv_e          priv_i
   , input                              timer_irq_i
   , input                              software_irq_i
   , input                              external_irq_i
   , input                              instret_i
   , input                              trap_take_i
   , input                              mret_i
   , input csr_isa_pkg::mstatus_u       mstatus_n_i
   , input [`XLEN-1:0]                  mepc_n_i
   , input [`XLEN-1:0]                  mcause_n_i
   , input [`XLEN-1:0]                  mtval_n_i
   , output logic [`XLEN-1:0]           rdata_o
   , output logic                       illegal_o
   , output csr_isa_pkg::mstatus_u      mstatus_o
   , output logic [`XLEN-1:0]           mtvec_o
   , output logic [`XLEN-1:0]           mepc_o
   , output logic [`XLEN-1:0]           mie_o
   , output logic [`XLEN-1:0]           mip_o
   );

   import csr_isa_pkg::*;
   import csr_cmd_pkg::*;

   mstatus_u         mstatus_r;
   logic [`XLEN-1:0] mie_r, mtvec_r, mscratch_r, mip_r;
   logic [`XLEN-1:0] mepc_r, mcause_r, mtval_r;
   logic [`XLEN-1:0] mcycle, minstret, mcountinhibit;
   logic [2:0]       cnt_we;
   logic [`XLEN-1:0] src, wdata, rd_val, mip_n, mstatus_wr;
   logic             is_imm, is_csr_op, wr_req, known, csr_we;

   assign is_imm    = cmd_op_i inside {e_csrrwi, e_csrrsi, e_csrrci};
   assign is_csr_op = is_imm | (cmd_op_i inside {e_csrrw, e_csrrs, e_csrrc});
   assign src       = is_imm ? `XLEN'(cmd_data_i[4:0]) : cmd_data_i;

   // Set and clear with a zero source only read
   assign wr_req = is_csr_op & ((cmd_op_i inside {e_csrrw, e_csrrwi}) | (src != '0));

   always_comb
   begin
      rd_val = '0;
      known  = 1'b1;
      case (cmd_addr_i)
         `CSR_ADDR_MISA          : rd_val = `MISA_VALUE;
         `CSR_ADDR_MVENDORID     : rd_val = '0;
         `CSR_ADDR_MARCHID       : rd_val = '0;
         `CSR_ADDR_MIMPID        : rd_val = '0;
         `CSR_ADDR_MHARTID       : rd_val = hartid_i;
         `CSR_ADDR_MSTATUS       : rd_val = mstatus_r.word;
         `CSR_ADDR_MIE           : rd_val = mie_r;
         `CSR_ADDR_MTVEC         : rd_val = mtvec_r;
         `CSR_ADDR_MCOUNTINHIBIT : rd_val = mcountinhibit;
         `CSR_ADDR_MSCRATCH      : rd_val = mscratch_r;
         `CSR_ADDR_MEPC          : rd_val = mepc_r;
         `CSR_ADDR_MCAUSE        : rd_val = mcause_r;
         `CSR_ADDR_MTVAL         : rd_val = mtval_r;
         `CSR_ADDR_MIP           : rd_val = mip_r;
         `CSR_ADDR_MCYCLE        : rd_val = mcycle;
         `CSR_ADDR_MINSTRET      : rd_val = minstret;
         default                 : known = 1'b0;
      endcase
   end

   always_comb
   begin
      case (cmd_op_i)
         e_csrrw, e_csrrwi : wdata = src;
         e_csrrs, e_csrrsi : wdata = rd_val | src;
         e_csrrc, e_csrrci : wdata = rd_val & ~src;
         default           : wdata = '0;
      endcase
   end

   // Bits 11:10 of 2'b11 mark a read-only CSR
   // misa is read only too
   assign illegal_o = cmd_v_i & is_csr_op
                      & (~known | (priv_i < cmd_addr_i[9:8])
                         | (wr_req & ((cmd_addr_i[11:10] == 2'b11)
                                      | (cmd_addr_i == `CSR_ADDR_MISA))));

   assign csr_we = cmd_v_i & wr_req & ~trap_take_i & ~mret_i;

   always_comb
   begin
      mstatus_wr = wdata & `MSTATUS_MASK;
      // mpp only holds U or M
      mstatus_wr[12:11] = (wdata[12:11] == 2'b11) ? 2'b11 : 2'b00;
   end

   always_comb
   begin
      mip_n                     = '0;
      mip_n[`ECODE_M_SW_IRQ]    = software_irq_i;
      mip_n[`ECODE_M_TIMER_IRQ] = timer_irq_i;
      mip_n[`ECODE_M_EXT_IRQ]   = external_irq_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         mstatus_r.word <= '0;
         mie_r          <= '0;
         mtvec_r        <= '0;
         mscratch_r     <= '0;
         mepc_r         <= '0;
         mcause_r       <= '0;
         mtval_r        <= '0;
         mip_r          <= '0;
      end
      else
      begin
         mip_r <= mip_n;
         if (trap_take_i | mret_i)
         begin
            mstatus_r <= mstatus_n_i;
            if (trap_take_i)
            begin
               mepc_r   <= mepc_n_i;
               mcause_r <= mcause_n_i;
               mtval_r  <= mtval_n_i;
            end
         end
         else if (csr_we)
         begin
            case (cmd_addr_i)
               `CSR_ADDR_MSTATUS  : mstatus_r.word <= mstatus_wr;
               `CSR_ADDR_MIE      : mie_r <= wdata & `MIE_MASK;
               `CSR_ADDR_MTVEC    : mtvec_r <= {wdata[`XLEN-1:2], 2'b00};
               `CSR_ADDR_MSCRATCH : mscratch_r <= wdata;
               `CSR_ADDR_MEPC     : mepc_r <= {wdata[`XLEN-1:2], 2'b00};
               `CSR_ADDR_MCAUSE   : mcause_r <= wdata;
               `CSR_ADDR_MTVAL    : mtval_r <= wdata;
               default            : ;
            endcase
         end
      end
   end

   assign cnt_we[0] = csr_we & (cmd_addr_i == `CSR_ADDR_MCYCLE);
   assign cnt_we[1] = csr_we & (cmd_addr_i == `CSR_ADDR_MINSTRET);
   assign cnt_we[2] = csr_we & (cmd_addr_i == `CSR_ADDR_MCOUNTINHIBIT);

   csr_counters counters0
     (.clk_i            (clk_i)
      , .rst_i          (rst_i)
      , .instret_i      (instret_i)
      , .cnt_we_i       (cnt_we)
      , .cnt_wdata_i    (wdata)
      , .mcycle_o       (mcycle)
      , .minstret_o     (minstret)
      , .mcountinhibit_o(mcountinhibit)
      );

   assign rdata_o   = rd_val;
   assign mstatus_o = mstatus_r;
   assign mtvec_o   = mtvec_r;
   assign mepc_o    = mepc_r;
   assign mie_o     = mie_r;
   assign mip_o     = mip_r;

   // An illegal access traps, and the trap blocks every CSR and counter write
   no_illegal_wr_a : assert property (@(posedge clk_i) disable iff (rst_i)
      illegal_o |-> !csr_we);

endmodule

// ==== design/csr_isa_pkg.sv ====
`include "csr_macros.svh"

package csr_isa_pkg;

   // Only U and M are implemented
   typedef enum logic [1:0]
   {
      e_priv_u = 2'd0,
      e_priv_m = 2'd3
   } priv_e;

   typedef struct packed
   {
      logic [50:0] rsvd_63_13;
      priv_e       mpp;
      logic [2:0]  rsvd_10_8;
      logic        mpie;
      logic [2:0]  rsvd_6_4;
      logic        mie;
      logic [2:0]  rsvd_2_0;
   } mstatus_s;

   // Word view for CSR access, field view for trap entry and return
   typedef union packed
   {
      logic [`XLEN-1:0] word;
      mstatus_s         fields;
   } mstatus_u;

endpackage

// ==== design/csr_macros.svh ====
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

`define XLEN 64

// Machine information, read only
`define CSR_ADDR_MVENDORID      12'hf11
`define CSR_ADDR_MARCHID        12'hf12
`define CSR_ADDR_MIMPID         12'hf13
`define CSR_ADDR_MHARTID        12'hf14

// Machine trap setup and handling
`define CSR_ADDR_MSTATUS        12'h300
`define CSR_ADDR_MISA           12'h301
`define CSR_ADDR_MIE            12'h304
`define CSR_ADDR_MTVEC          12'h305
`define CSR_ADDR_MCOUNTINHIBIT  12'h320
`define CSR_ADDR_MSCRATCH       12'h340
`define CSR_ADDR_MEPC           12'h341
`define CSR_ADDR_MCAUSE         12'h342
`define CSR_ADDR_MTVAL          12'h343
`define CSR_ADDR_MIP            12'h344

// Machine counters
`define CSR_ADDR_MCYCLE         12'hb00
`define CSR_ADDR_MINSTRET       12'hb02

// Exception codes
`define ECODE_ILLEGAL_INSTR     4'd2
`define ECODE_BREAKPOINT        4'd3
`define ECODE_LOAD_MISALIGNED   4'd4
`define ECODE_STORE_MISALIGNED  4'd6
`define ECODE_ECALL_U           4'd8
`define ECODE_ECALL_M           4'd11

// Interrupt codes, also the bit positions in mie and mip
`define ECODE_M_SW_IRQ          4'd3
`define ECODE_M_TIMER_IRQ       4'd7
`define ECODE_M_EXT_IRQ         4'd11

// RV64 with A, I, M and U
`define MISA_VALUE              64'h8000_0000_0010_1101

// Writable bits
`define MSTATUS_MASK            64'h0000_0000_0000_1888
`define MIE_MASK                64'h0000_0000_0000_0888
`define MCOUNTINHIBIT_MASK      64'h0000_0000_0000_0005

`endif

// ==== design/csr_trap_ctrl.sv ====
`timescale 1ns/1ns
`include "csr_macros.svh"

module csr_trap_ctrl
  (input                                clk_i
   , input                              rst_i
   , input                              cmd_v_i
   , input csr_cmd_pkg::csr_op_e        cmd_op_i
   , input [`XLEN-1:0]                  epc_i
   , input [`XLEN-1:0]                  tval_i
   , input                              illegal_i
   , input csr_isa_pkg::mstatus_u       mstatus_i
   , input [`XLEN-1:0]                  mtvec_i
   , input [`XLEN-1:0]                  mepc_i
   , input [`XLEN-1:0]                  mie_i
   , input [`XLEN-1:0]                  mip_i
   , output csr_isa_pkg::priv_e         priv_o
   , output logic                       trap_take_o
   , output logic                       mret_o
   , output logic                       irq_o
   , output logic [`XLEN-1:0]           cause_o
   , output logic [`XLEN-1:0]           target_pc_o
   , output csr_isa_pkg::mstatus_u      mstatus_n_o
   , output logic [`XLEN-1:0]           mepc_n_o
   , output logic [`XLEN-1:0]           mcause_n_o
   , output logic [`XLEN-1:0]           mtval_n_o
   );

   import csr_isa_pkg::*;
   import csr_cmd_pkg::*;

   priv_e            priv_r, priv_n;
   logic             mret_cmd, mret_ill, is_ecall, exc_v, irq_v;
   logic [3:0]       ecode, icode;
   logic [`XLEN-1:0] pend;

   assign mret_cmd = cmd_v_i & (cmd_op_i == e_mret);
   assign mret_ill = mret_cmd & (priv_r == e_priv_u);
   assign is_ecall = cmd_v_i & (cmd_op_i == e_ecall);

   // Fixed exception priority
   always_comb
   begin
      exc_v = cmd_v_i;
      ecode = '0;
      if (illegal_i | mret_ill | (cmd_op_i == e_exc_illegal))
         ecode = `ECODE_ILLEGAL_INSTR;
      else if (cmd_op_i == e_ebreak)
         ecode = `ECODE_BREAKPOINT;
      else if (cmd_op_i == e_ecall)
         ecode = (priv_r == e_priv_u) ? `ECODE_ECALL_U : `ECODE_ECALL_M;
      else if (cmd_op_i == e_exc_load_misaligned)
         ecode = `ECODE_LOAD_MISALIGNED;
      else if (cmd_op_i == e_exc_store_misaligned)
         ecode = `ECODE_STORE_MISALIGNED;
      else
         exc_v = 1'b0;
   end

   // External first, then software, then timer
   assign pend = mie_i & mip_i;
   always_comb
   begin
      if (pend[`ECODE_M_EXT_IRQ])
         icode = `ECODE_M_EXT_IRQ;
      else if (pend[`ECODE_M_SW_IRQ])
         icode = `ECODE_M_SW_IRQ;
      else
         icode = `ECODE_M_TIMER_IRQ;
   end

   // Only in a cycle without a command
   assign irq_v = ~cmd_v_i & (mstatus_i.fields.mie | (priv_r == e_priv_u))
                  & (pend[`ECODE_M_EXT_IRQ] | pend[`ECODE_M_SW_IRQ] | pend[`ECODE_M_TIMER_IRQ]);

   assign trap_take_o = exc_v | irq_v;
   assign mret_o      = mret_cmd & ~mret_ill;
   assign irq_o       = irq_v;
   assign cause_o     = {irq_v, {(`XLEN-5){1'b0}}, irq_v ? icode : ecode};
   assign target_pc_o = trap_take_o ? mtvec_i : (mret_o ? mepc_i : '0);
   assign mepc_n_o    = epc_i;
   assign mcause_n_o  = cause_o;
   assign mtval_n_o   = (irq_v | is_ecall) ? '0 : tval_i;

   always_comb
   begin
      mstatus_n_o = mstatus_i;
      priv_n      = priv_r;
      if (trap_take_o)
      begin
         mstatus_n_o.fields.mpp  = priv_r;
         mstatus_n_o.fields.mpie = mstatus_i.fields.mie;
         mstatus_n_o.fields.mie  = 1'b0;
         priv_n                  = e_priv_m;
      end
      else if (mret_o)
      begin
         mstatus_n_o.fields.mie  = mstatus_i.fields.mpie;
         mstatus_n_o.fields.mpie = 1'b1;
         mstatus_n_o.fields.mpp  = e_priv_u;
         priv_n                  = mstatus_i.fields.mpp;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
         priv_r <= e_priv_m;
      else
         priv_r <= priv_n;
   end

   assign priv_o = priv_r;

   trap_mret_excl_a : assert property (@(posedge clk_i) disable iff (rst_i)
      !(trap_take_o && mret_o));

endmodule

// ==== design/csr_unit.sv ====
`timescale 1ns/1ns
`include "csr_macros.svh"

module csr_unit
  (input                                clk_i
   , input                              rst_i
   , input                              cmd_v_i
   , input csr_cmd_pkg::csr_op_e        cmd_op_i
   , input [11:0]                       cmd_addr_i
   , input [`XLEN-1:0]                  cmd_data_i
   , input [`XLEN-1:0]                  epc_i
   , input [`XLEN-1:0]                  tval_i
   , input                              timer_irq_i
   , input                              software_irq_i
   , input                              external_irq_i
   , input                              instret_i
   , input [`XLEN-1:0]                  hartid_i
   , output logic                       resp_v_o
   , output logic [`XLEN-1:0]           rdata_o
   , output logic                       illegal_o
   , output logic                       trap_o
   , output logic                       irq_o
   , output logic [`XLEN-1:0]           cause_o
   , output logic [`XLEN-1:0]           target_pc_o
   , output csr_isa_pkg::priv_e         priv_o
   );

   import csr_isa_pkg::*;

   priv_e            priv;
   mstatus_u         mstatus, mstatus_n;
   logic [`XLEN-1:0] rdata, mtvec, mepc, mie, mip;
   logic [`XLEN-1:0] cause, target_pc, mepc_n, mcause_n, mtval_n;
   logic             illegal, trap_take, mret, irq;

   csr_file file0
     (.clk_i           (clk_i)
      , .rst_i         (rst_i)
      , .cmd_v_i       (cmd_v_i)
      , .cmd_op_i      (cmd_op_i)
      , .cmd_addr_i    (cmd_addr_i)
      , .cmd_data_i    (cmd_data_i)
      , .hartid_i      (hartid_i)
      , .priv_i        (priv)
      , .timer_irq_i   (timer_irq_i)
      , .software_irq_i(software_irq_i)
      , .external_irq_i(external_irq_i)
      , .instret_i     (instret_i)
      , .trap_take_i   (trap_take)
      , .mret_i        (mret)
      , .mstatus_n_i   (mstatus_n)
      , .mepc_n_i      (mepc_n)
      , .mcause_n_i    (mcause_n)
      , .mtval_n_i     (mtval_n)
      , .rdata_o       (rdata)
      , .illegal_o     (illegal)
      , .mstatus_o     (mstatus)
      , .mtvec_o       (mtvec)
      , .mepc_o        (mepc)
      , .mie_o         (mie)
      , .mip_o         (mip)
      );

   csr_trap_ctrl trap0
     (.clk_i        (clk_i)
      , .rst_i      (rst_i)
      , .cmd_v_i    (cmd_v_i)
      , .cmd_op_i   (cmd_op_i)
      , .epc_i      (epc_i)
      , .tval_i     (tval_i)
      , .illegal_i  (illegal)
      , .mstatus_i  (mstatus)
      , .mtvec_i    (mtvec)
      , .mepc_i     (mepc)
      , .mie_i      (mie)
      , .mip_i      (mip)
      , .priv_o     (priv)
      , .trap_take_o(trap_take)
      , .mret_o     (mret)
      , .irq_o      (irq)
      , .cause_o    (cause)
      , .target_pc_o(target_pc)
      , .mstatus_n_o(mstatus_n)
      , .mepc_n_o   (mepc_n)
      , .mcause_n_o (mcause_n)
      , .mtval_n_o  (mtval_n)
      );

   // Results appear one cycle after the accepting edge
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         resp_v_o    <= 1'b0;
         illegal_o   <= 1'b0;
         trap_o      <= 1'b0;
         irq_o       <= 1'b0;
         rdata_o     <= '0;
         cause_o     <= '0;
         target_pc_o <= '0;
      end
      else
      begin
         resp_v_o    <= cmd_v_i | irq;
         illegal_o   <= illegal;
         trap_o      <= trap_take;
         irq_o       <= irq;
         rdata_o     <= rdata;
         cause_o     <= cause;
         target_pc_o <= target_pc;
      end
   end

   // Mode register already changes at the accepting edge
   assign priv_o = priv;

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
   -f src.f --top-module tb_csr_unit -o tb_csr_unit

sim_out=$(./obj_dir/tb_csr_unit)
echo "${sim_out}"

if grep -qx "Everything OK" <<< "${sim_out}"; then
   exit 0
fi
exit 1

// ==== src.f ====
+incdir+design
+incdir+bench
design/csr_isa_pkg.sv
design/csr_cmd_pkg.sv
design/csr_counters.sv
design/csr_file.sv
design/csr_trap_ctrl.sv
design/csr_unit.sv
bench/tb_csr_unit.sv
